/* Bender.yml */
package:
  name: rv_core

sources:
  - hdl/rv_core_pkg.sv
  - hdl/rv_fetch.sv
  - hdl/rv_decode.sv
  - hdl/rv_regfile.sv
  - hdl/rv_execute.sv
  - hdl/rv_store_bus.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - bench/rv_core_assert.sv
      - bench/tb_rv_core.sv

/* bench/rv_core_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_assert (
  input wire                           clk_i,
  input wire                           reset_i,
  input wire                           cyc_i,
  input wire                           stb_i,
  input wire                           we_i,
  input wire                           ack_i,
  input wire [3:0]                     sel_i,
  input wire [rv_core_pkg::adr_w-1:0]  adr_i,
  input rv_core_pkg::word_t            dat_i
);

  // strobe only inside a bus cycle
  stb_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i) stb_i |-> cyc_i)
    else $error("stb_o high without cyc_o");

  // request held until acknowledged
  request_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(we_i) && $stable(sel_i)))
    else $error("bus request changed before ack_i");

  write_data_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (stb_i && we_i && !ack_i) |=> $stable(dat_i))
    else $error("write data changed before ack_i");

  full_word_write: assert property (@(posedge clk_i) disable iff (reset_i)
    we_i |-> (sel_i == 4'hf))
    else $error("we_o without all byte selects");

endmodule

bind rv_core rv_core_assert u_assert (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .cyc_i   (cyc_o),
  .stb_i   (stb_o),
  .we_i    (we_o),
  .ack_i   (ack_i),
  .sel_i   (sel_o),
  .adr_i   (adr_o),
  .dat_i   (master_dat_o)
);

`default_nettype wire

/* bench/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam rv_core_pkg::word_t reset_pc   = 32'h0000_0100;
  localparam rv_core_pkg::word_t store_base = 32'h0000_0400;
  localparam int mem_words     = 1024;
  localparam int max_rows      = 40;
  localparam int bus_timeout   = 50;
  localparam int store_timeout = 400;

  logic                          clk_i = 1'b0;
  logic                          reset_i;
  rv_core_pkg::word_t            master_dat_i;
  logic                          ack_i;
  rv_core_pkg::word_t            master_dat_o;
  logic [rv_core_pkg::adr_w-1:0] adr_o;
  logic                          cyc_o;
  logic                          stb_o;
  logic                          we_o;
  logic [3:0]                    sel_o;

  // word-addressed memory behind the bus
  rv_core_pkg::word_t mem [0:mem_words-1];

  // program table with one row per instruction
  rv_core_pkg::word_t row_instr [0:max_rows-1];
  logic               row_store [0:max_rows-1];
  logic [31:0]        row_adr   [0:max_rows-1];
  rv_core_pkg::word_t row_data  [0:max_rows-1];
  int                 row_count = 0;

  // writes seen on the bus in arrival order
  logic [31:0] st_adr_q[$];
  logic [31:0] st_dat_q[$];
  logic [31:0] st_sel_q[$];

  logic [31:0] fetch_adr_exp = reset_pc >> 2;
  integer      seed = 32'h8385;
  int          error_count = 0;

  rv_core #(
    .reset_pc (reset_pc)
  ) DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .master_dat_i (master_dat_i),
    .ack_i        (ack_i),
    .master_dat_o (master_dat_o),
    .adr_o        (adr_o),
    .cyc_o        (cyc_o),
    .stb_o        (stb_o),
    .we_o         (we_o),
    .sel_o        (sel_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic stop_with_failure;
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction encoding
  //////////////////////////////////////////////////////////////////////

  function automatic rv_core_pkg::word_t enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
    enc_i = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
    enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_core_pkg::word_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
    enc_u = {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(input rv_core_pkg::word_t instr, input logic is_store,
                         input logic [11:0] off, input rv_core_pkg::word_t data);
    row_instr[row_count] = instr;
    row_store[row_count] = is_store;
    row_adr[row_count]   = (store_base + {{20{off[11]}}, off}) >> 2;
    row_data[row_count]  = data;
    row_count++;
  endtask

  task automatic add_op(input rv_core_pkg::word_t instr);
    add_row(instr, 1'b0, 12'd0, '0);
  endtask

  // sw rs2, off(x10)
  task automatic add_store(input logic [4:0] rs2, input logic [11:0] off,
                           input rv_core_pkg::word_t data);
    add_row({off[11:5], rs2, 5'd10, 3'b010, off[4:0], 7'b0100011}, 1'b1, off, data);
  endtask

  task automatic build_program;
    rv_core_pkg::word_t v1;
    rv_core_pkg::word_t v2;
    rv_core_pkg::word_t v3;
    rv_core_pkg::word_t v15;
    v1  = 32'h12345 << 12;
    v2  = -5;
    v3  = 7;
    v15 = ((v3 + 1) + (v3 + 1)) - v3;
    add_op(enc_u(5'd1, 20'h12345));
    add_op(enc_i(3'b000, 5'd10, 5'd0, store_base[11:0]));
    add_store(5'd1, 12'd0, v1);
    add_op(enc_i(3'b000, 5'd2, 5'd0, 12'hffb));
    add_op(enc_i(3'b000, 5'd3, 5'd0, 12'd7));
    add_op(enc_r(7'h00, 3'b000, 5'd4, 5'd2, 5'd3));
    add_store(5'd4, 12'd4, v2 + v3);
    add_op(enc_r(7'h20, 3'b000, 5'd5, 5'd2, 5'd3));
    add_store(5'd5, 12'd8, v2 - v3);
    add_op(enc_r(7'h00, 3'b010, 5'd6, 5'd2, 5'd3));
    add_op(enc_r(7'h00, 3'b011, 5'd7, 5'd2, 5'd3));
    // -5 against 7 compared signed then unsigned
    add_store(5'd6, 12'd12, ($signed(v2) < $signed(v3)) ? 32'd1 : 32'd0);
    add_store(5'd7, 12'd16, (v2 < v3) ? 32'd1 : 32'd0);
    add_op(enc_r(7'h00, 3'b100, 5'd8, 5'd1, 5'd2));
    add_op(enc_r(7'h00, 3'b110, 5'd9, 5'd3, 5'd1));
    add_op(enc_r(7'h00, 3'b111, 5'd11, 5'd2, 5'd3));
    add_store(5'd8, 12'd20, v1 ^ v2);
    add_store(5'd9, 12'd24, v3 | v1);
    add_store(5'd11, 12'd28, v2 & v3);
    add_op(enc_i(3'b110, 5'd12, 5'd3, 12'h0f0));
    add_op(enc_i(3'b100, 5'd13, 5'd2, 12'hfff));
    add_op(enc_i(3'b010, 5'd14, 5'd2, 12'hffc));
    add_op(enc_i(3'b111, 5'd16, 5'd2, 12'h0f0));
    add_store(5'd12, 12'd32, v3 | 32'h0000_00f0);
    add_store(5'd13, 12'd36, v2 ^ 32'hffff_ffff);
    add_store(5'd14, 12'd40, ($signed(v2) < -4) ? 32'd1 : 32'd0);
    add_store(5'd16, 12'd44, v2 & 32'h0000_00f0);
    // x0 ignores the write
    add_op(enc_i(3'b000, 5'd0, 5'd3, 12'd99));
    add_store(5'd0, 12'd48, 32'd0);
    // dependent chain on x15
    add_op(enc_i(3'b000, 5'd15, 5'd3, 12'd1));
    add_op(enc_r(7'h00, 3'b000, 5'd15, 5'd15, 5'd15));
    add_op(enc_r(7'h20, 3'b000, 5'd15, 5'd15, 5'd3));
    add_store(5'd15, 12'd52, v15);
    // lw x1 is outside the subset and must leave x1 alone
    add_op(32'h0005_2083);
    add_store(5'd1, 12'd56, v1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus slave with random ack latency
  //////////////////////////////////////////////////////////////////////

  initial begin : bus_model
    int delay;
    int waited;
    @(posedge clk_i);
    #2;
    forever begin
      waited = 0;
      while (stb_o !== 1'b1) begin
        if (waited == bus_timeout) begin
          $display("Timeout: the core made no bus request for %0d cycles", bus_timeout);
          stop_with_failure;
        end
        @(posedge clk_i);
        #2;
        waited++;
      end
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        @(posedge clk_i);
        #2;
      end
      if (we_o) begin
        st_adr_q.push_back(adr_o);
        st_dat_q.push_back(master_dat_o);
        st_sel_q.push_back(sel_o);
        if (adr_o < mem_words) begin
          mem[adr_o] = master_dat_o;
        end
      end else begin
        // reads walk through memory one word at a time
        check("fetch address", adr_o, fetch_adr_exp);
        fetch_adr_exp++;
        master_dat_i = (adr_o < mem_words) ? mem[adr_o] : '0;
      end
      ack_i = 1'b1;
      @(posedge clk_i);
      #2;
      ack_i = 1'b0;
    end
  end

  initial begin : main
    int i;
    int waited;
    reset_i      = 1'b1;
    ack_i        = 1'b0;
    master_dat_i = '0;
    for (i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
    build_program;
    for (i = 0; i < row_count; i++) begin
      mem[(reset_pc >> 2) + i] = row_instr[i];
    end
    repeat (4) begin
      @(posedge clk_i);
      #2;
      check("cyc_o in reset", cyc_o, 1'b0);
      check("stb_o in reset", stb_o, 1'b0);
      check("we_o in reset", we_o, 1'b0);
    end
    reset_i = 1'b0;
    @(posedge clk_i);
    #2;
    check("cyc_o after reset", cyc_o, 1'b0);
    check("stb_o after reset", stb_o, 1'b0);
    check("we_o after reset", we_o, 1'b0);
    for (i = 0; i < row_count; i++) begin
      if (row_store[i]) begin
        waited = 0;
        while (st_adr_q.size() == 0) begin
          if (waited == store_timeout) begin
            $display("Timeout: the store of program row %0d never reached the bus", i);
            stop_with_failure;
          end
          @(posedge clk_i);
          #2;
          waited++;
        end
        check("store address", st_adr_q.pop_front(), row_adr[i]);
        check("store data", st_dat_q.pop_front(), row_data[i]);
        check("store sel", st_sel_q.pop_front(), 32'h0000_000f);
      end
    end
    // trailing no-ops must not write
    repeat (20) begin
      @(posedge clk_i);
    end
    check("extra stores", st_adr_q.size(), 32'd0);
    if (error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  rv_core_pkg::word_t            master_dat_i,
  input  wire                           ack_i,
  output rv_core_pkg::word_t            master_dat_o,
  output logic [rv_core_pkg::adr_w-1:0] adr_o,
  output logic                          cyc_o,
  output logic                          stb_o,
  output logic                          we_o,
  output logic [3:0]                    sel_o
);

  //////////////////////////////////////////////////////////////////////
  // stage wiring
  //////////////////////////////////////////////////////////////////////

  logic                          fetch_req;
  logic [rv_core_pkg::adr_w-1:0] fetch_adr;
  logic                          fetch_grant;
  logic                          fetch_ack;
  rv_core_pkg::word_t            instr;
  logic                          instr_valid;
  logic                          decode_ready;

  logic                          dec_valid;
  rv_core_pkg::alu_op_e          dec_op;
  rv_core_pkg::reg_addr_t        dec_rd;
  rv_core_pkg::reg_addr_t        dec_rs1;
  rv_core_pkg::reg_addr_t        dec_rs2;
  rv_core_pkg::word_t            dec_imm;
  logic                          dec_use_imm;
  logic                          dec_store;
  logic                          dec_lui;
  logic                          exec_ready;

  rv_core_pkg::reg_addr_t        rs1_addr;
  rv_core_pkg::reg_addr_t        rs2_addr;
  rv_core_pkg::word_t            rs1_data;
  rv_core_pkg::word_t            rs2_data;
  logic                          wb_we;
  rv_core_pkg::reg_addr_t        wb_addr;
  rv_core_pkg::word_t            wb_data;

  logic                          st_req;
  logic [rv_core_pkg::adr_w-1:0] st_adr;
  rv_core_pkg::word_t            st_data;
  logic                          st_done;

  rv_fetch #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_grant_i  (fetch_grant),
    .fetch_ack_i    (fetch_ack),
    .bus_dat_i      (master_dat_i),
    .decode_ready_i (decode_ready),
    .fetch_req_o    (fetch_req),
    .fetch_adr_o    (fetch_adr),
    .instr_o        (instr),
    .instr_valid_o  (instr_valid)
  );

  rv_decode u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_i        (instr),
    .instr_valid_i  (instr_valid),
    .exec_ready_i   (exec_ready),
    .decode_ready_o (decode_ready),
    .dec_valid_o    (dec_valid),
    .dec_op_o       (dec_op),
    .dec_rd_o       (dec_rd),
    .dec_rs1_o      (dec_rs1),
    .dec_rs2_o      (dec_rs2),
    .dec_imm_o      (dec_imm),
    .dec_use_imm_o  (dec_use_imm),
    .dec_store_o    (dec_store),
    .dec_lui_o      (dec_lui)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wb_we),
    .wr_addr_i  (wb_addr),
    .wr_data_i  (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute u_execute (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dec_valid_i   (dec_valid),
    .dec_op_i      (dec_op),
    .dec_rd_i      (dec_rd),
    .dec_rs1_i     (dec_rs1),
    .dec_rs2_i     (dec_rs2),
    .dec_imm_i     (dec_imm),
    .dec_use_imm_i (dec_use_imm),
    .dec_store_i   (dec_store),
    .dec_lui_i     (dec_lui),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .st_done_i     (st_done),
    .exec_ready_o  (exec_ready),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .wb_we_o       (wb_we),
    .wb_addr_o     (wb_addr),
    .wb_data_o     (wb_data),
    .st_req_o      (st_req),
    .st_adr_o      (st_adr),
    .st_data_o     (st_data)
  );

  rv_store_bus u_store_bus (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req),
    .fetch_adr_i   (fetch_adr),
    .st_req_i      (st_req),
    .st_adr_i      (st_adr),
    .st_data_i     (st_data),
    .ack_i         (ack_i),
    .fetch_grant_o (fetch_grant),
    .fetch_ack_o   (fetch_ack),
    .st_done_o     (st_done),
    .adr_o         (adr_o),
    .cyc_o         (cyc_o),
    .stb_o         (stb_o),
    .we_o          (we_o),
    .sel_o         (sel_o),
    .master_dat_o  (master_dat_o)
  );

endmodule

`default_nettype wire

/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and word types
  //////////////////////////////////////////////////////////////////////

  localparam int xlen = 32;
  // bus addresses whole words
  localparam int adr_w = xlen - 2;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_store = 7'b0100011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu
  } alu_op_e;

endpackage

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  rv_core_pkg::word_t     instr_i,
  input  wire                    instr_valid_i,
  input  wire                    exec_ready_i,
  output logic                   decode_ready_o,
  output logic                   dec_valid_o,
  output rv_core_pkg::alu_op_e   dec_op_o,
  output rv_core_pkg::reg_addr_t dec_rd_o,
  output rv_core_pkg::reg_addr_t dec_rs1_o,
  output rv_core_pkg::reg_addr_t dec_rs2_o,
  output rv_core_pkg::word_t     dec_imm_o,
  output logic                   dec_use_imm_o,
  output logic                   dec_store_o,
  output logic                   dec_lui_o
);

  rv_core_pkg::opcode_e   opcode;
  logic [2:0]             funct3;
  rv_core_pkg::alu_op_e   op;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t     imm;
  logic                   use_imm;
  logic                   store;
  logic                   lui;
  logic                   accept;

  assign opcode = rv_core_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  always_comb begin
    op      = rv_core_pkg::alu_add;
    rd      = '0;
    imm     = {{20{instr_i[31]}}, instr_i[31:20]};
    use_imm = 1'b0;
    store   = 1'b0;
    lui     = 1'b0;
    case (opcode)
      rv_core_pkg::op_lui: begin
        rd  = instr_i[11:7];
        imm = {instr_i[31:12], 12'b0};
        lui = 1'b1;
      end
      rv_core_pkg::op_imm: begin
        rd      = instr_i[11:7];
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = rv_core_pkg::alu_add;
          3'b010: op = rv_core_pkg::alu_slt;
          3'b100: op = rv_core_pkg::alu_xor;
          3'b110: op = rv_core_pkg::alu_or;
          3'b111: op = rv_core_pkg::alu_and;
          default: rd = '0;
        endcase
      end
      rv_core_pkg::op_reg: begin
        rd = instr_i[11:7];
        case (funct3)
          3'b000: op = instr_i[30] ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
          3'b010: op = rv_core_pkg::alu_slt;
          3'b011: op = rv_core_pkg::alu_sltu;
          3'b100: op = rv_core_pkg::alu_xor;
          3'b110: op = rv_core_pkg::alu_or;
          3'b111: op = rv_core_pkg::alu_and;
          default: rd = '0;
        endcase
      end
      rv_core_pkg::op_store: begin
        // store widths other than a word fall through as no-ops
        imm     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        use_imm = 1'b1;
        store   = (funct3 == 3'b010);
      end
      default: rd = '0;
    endcase
  end

  assign decode_ready_o = ~dec_valid_o | exec_ready_i;
  assign accept = instr_valid_i & decode_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
    end else if (exec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_op_o      <= op;
      dec_rd_o      <= rd;
      dec_rs1_o     <= lui ? 5'd0 : instr_i[19:15];
      dec_rs2_o     <= instr_i[24:20];
      dec_imm_o     <= imm;
      dec_use_imm_o <= use_imm;
      dec_store_o   <= store;
      dec_lui_o     <= lui;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire                           dec_valid_i,
  input  rv_core_pkg::alu_op_e          dec_op_i,
  input  rv_core_pkg::reg_addr_t        dec_rd_i,
  input  rv_core_pkg::reg_addr_t        dec_rs1_i,
  input  rv_core_pkg::reg_addr_t        dec_rs2_i,
  input  rv_core_pkg::word_t            dec_imm_i,
  input  wire                           dec_use_imm_i,
  input  wire                           dec_store_i,
  input  wire                           dec_lui_i,
  input  rv_core_pkg::word_t            rs1_data_i,
  input  rv_core_pkg::word_t            rs2_data_i,
  input  wire                           st_done_i,
  output logic                          exec_ready_o,
  output rv_core_pkg::reg_addr_t        rs1_addr_o,
  output rv_core_pkg::reg_addr_t        rs2_addr_o,
  output logic                          wb_we_o,
  output rv_core_pkg::reg_addr_t        wb_addr_o,
  output rv_core_pkg::word_t            wb_data_o,
  output logic                          st_req_o,
  output logic [rv_core_pkg::adr_w-1:0] st_adr_o,
  output rv_core_pkg::word_t            st_data_o
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t fwd_b;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t result;
  logic               consume;

  assign rs1_addr_o = dec_rs1_i;
  assign rs2_addr_o = dec_rs2_i;

  // bypass from the writeback register
  assign op_a  = (wb_we_o && (wb_addr_o != 5'd0) && (wb_addr_o == dec_rs1_i)) ?
                 wb_data_o : rs1_data_i;
  assign fwd_b = (wb_we_o && (wb_addr_o != 5'd0) && (wb_addr_o == dec_rs2_i)) ?
                 wb_data_o : rs2_data_i;
  assign op_b  = dec_use_imm_i ? dec_imm_i : fwd_b;

  always_comb begin
    case (dec_op_i)
      rv_core_pkg::alu_sub:  alu_result = op_a - op_b;
      rv_core_pkg::alu_and:  alu_result = op_a & op_b;
      rv_core_pkg::alu_or:   alu_result = op_a | op_b;
      rv_core_pkg::alu_xor:  alu_result = op_a ^ op_b;
      rv_core_pkg::alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::alu_sltu: alu_result = {31'b0, op_a < op_b};
      default:               alu_result = op_a + op_b;
    endcase
  end

  assign result       = dec_lui_i ? dec_imm_i : alu_result;
  assign exec_ready_o = ~st_req_o;
  assign consume      = dec_valid_i & exec_ready_o;

  //////////////////////////////////////////////////////////////////////
  // writeback and store control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_we_o  <= 1'b0;
      st_req_o <= 1'b0;
    end else begin
      wb_we_o <= consume & ~dec_store_i & (dec_rd_i != 5'd0);
      if (consume && dec_store_i) begin
        st_req_o <= 1'b1;
      end else if (st_done_i) begin
        st_req_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      wb_addr_o <= dec_rd_i;
      wb_data_o <= result;
    end
    // address and data stay put while the store runs
    if (consume && dec_store_i) begin
      st_adr_o  <= alu_result[rv_core_pkg::xlen-1:2];
      st_data_o <= fwd_b;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
  parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire                             fetch_grant_i,
  input  wire                             fetch_ack_i,
  input  rv_core_pkg::word_t              bus_dat_i,
  input  wire                             decode_ready_i,
  output logic                            fetch_req_o,
  output logic [rv_core_pkg::adr_w-1:0]   fetch_adr_o,
  output rv_core_pkg::word_t              instr_o,
  output logic                            instr_valid_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_full
  } state_e;

  state_e             state_q;
  rv_core_pkg::word_t pc_q;
  rv_core_pkg::word_t instr_q;
  logic               bus_done;
  logic               take;

  assign bus_done = fetch_grant_i & fetch_ack_i;
  // decode empties the buffer this cycle
  assign take = (state_q == st_full) & decode_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
      pc_q    <= reset_pc;
    end else begin
      case (state_q)
        st_idle: state_q <= st_request;
        st_request: begin
          if (bus_done) begin
            state_q <= st_full;
            pc_q    <= pc_q + 32'd4;
          end
        end
        st_full: begin
          if (take) begin
            state_q <= st_request;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // one-word instruction buffer
  always_ff @(posedge clk_i) begin
    if ((state_q == st_request) && bus_done) begin
      instr_q <= bus_dat_i;
    end
  end

  assign fetch_req_o   = (state_q == st_request);
  assign fetch_adr_o   = pc_q[rv_core_pkg::xlen-1:2];
  assign instr_o       = instr_q;
  assign instr_valid_o = (state_q == st_full);

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  wire                    clk_i,
  input  rv_core_pkg::reg_addr_t rs1_addr_i,
  input  rv_core_pkg::reg_addr_t rs2_addr_i,
  input  wire                    wr_en_i,
  input  rv_core_pkg::reg_addr_t wr_addr_i,
  input  rv_core_pkg::word_t     wr_data_i,
  output rv_core_pkg::word_t     rs1_data_o,
  output rv_core_pkg::word_t     rs2_data_o
);

  // x0 has no storage
  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (wr_en_i && (wr_addr_i != 5'd0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* hdl/rv_store_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_store_bus (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire                           fetch_req_i,
  input  wire [rv_core_pkg::adr_w-1:0]  fetch_adr_i,
  input  wire                           st_req_i,
  input  wire [rv_core_pkg::adr_w-1:0]  st_adr_i,
  input  rv_core_pkg::word_t            st_data_i,
  input  wire                           ack_i,
  output logic                          fetch_grant_o,
  output logic                          fetch_ack_o,
  output logic                          st_done_o,
  output logic [rv_core_pkg::adr_w-1:0] adr_o,
  output logic                          cyc_o,
  output logic                          stb_o,
  output logic                          we_o,
  output logic [3:0]                    sel_o,
  output rv_core_pkg::word_t            master_dat_o
);

  logic busy_q;
  // high while the store side owns the bus
  logic owner_st_q;

  // owner only changes while the bus is idle and a store goes first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      owner_st_q <= 1'b0;
    end else if (busy_q) begin
      if (ack_i) begin
        busy_q <= 1'b0;
      end
    end else if (st_req_i) begin
      busy_q     <= 1'b1;
      owner_st_q <= 1'b1;
    end else if (fetch_req_i) begin
      busy_q     <= 1'b1;
      owner_st_q <= 1'b0;
    end
  end

  assign fetch_grant_o = busy_q & ~owner_st_q;
  assign fetch_ack_o   = fetch_grant_o & ack_i;
  assign st_done_o     = busy_q & owner_st_q & ack_i;

  assign cyc_o        = busy_q;
  assign stb_o        = busy_q;
  assign we_o         = busy_q & owner_st_q;
  assign sel_o        = {4{we_o}};
  assign adr_o        = owner_st_q ? st_adr_i : fetch_adr_i;
  assign master_dat_o = st_data_i;

endmodule

`default_nettype wire

/* tb.f */
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_store_bus.sv
hdl/rv_core.sv
bench/rv_core_assert.sv
bench/tb_rv_core.sv
